// ==== rtl/ex_pkg.sv ====
// execute stage package
// operation codes, data width and fall-through increments used by every
// block of the stage

package ex_pkg;

  ////////////////////////////////////////
  // widths
  ////////////////////////////////////////

  // data and address width of the core
  parameter int unsigned XLEN = 32;

  // width of the operation field coming from decode
  parameter int unsigned ALU_OP_W = 4;

  ////////////////////////////////////////
  // operation codes
  ////////////////////////////////////////

  // the first seven codes produce a register result
  // the last six are branch compares and only drive the compare flag
  typedef enum logic [ALU_OP_W-1:0] {
    ALU_ADD  = 4'h0,
    ALU_SUB  = 4'h1,
    ALU_AND  = 4'h2,
    ALU_OR   = 4'h3,
    ALU_XOR  = 4'h4,
    ALU_SLT  = 4'h5,
    ALU_SLTU = 4'h6,
    ALU_BEQ  = 4'h8,
    ALU_BNE  = 4'h9,
    ALU_BLT  = 4'hA,
    ALU_BGE  = 4'hB,
    ALU_BLTU = 4'hC,
    ALU_BGEU = 4'hD
  } alu_op_e;

  ////////////////////////////////////////
  // pc increments
  ////////////////////////////////////////

  // fall-through step for a compressed instruction
  parameter logic [XLEN-1:0] PC_INC_C = 32'd2;
  // fall-through step for a full width instruction
  parameter logic [XLEN-1:0] PC_INC_U = 32'd4;

endpackage

// ==== rtl/ex_alu.sv ====
// execute stage ALU
// add, subtract, logic and set-less-than on the held operands, plus the
// compare flag for the six branch conditions

`timescale 1ns/1ps

module ex_alu
  import ex_pkg::*;
(
  input  logic            clk,
  input  logic            reset_i,
  input  alu_op_e         op_i,
  input  logic [XLEN-1:0] op_a_i,
  input  logic [XLEN-1:0] op_b_i,
  input  logic            valid_i,
  output logic [XLEN-1:0] result_o,
  output logic            cmp_o
);

  ////////////////////////////////////////
  // shared adder and compare terms
  ////////////////////////////////////////

  logic [XLEN-1:0] sum;
  logic [XLEN:0]   diff;
  logic            equal;
  logic            less_u;
  logic            less_s;
  logic            is_branch_op;

  assign sum = op_a_i + op_b_i;

  // one extra bit on the subtraction so the top bit is the unsigned borrow
  assign diff = {1'b0, op_a_i} - {1'b0, op_b_i};

  assign equal  = (op_a_i == op_b_i);
  assign less_u = diff[XLEN];

  // when the signs differ the negative operand is the smaller one
  // otherwise the sign of the difference decides
  assign less_s = (op_a_i[XLEN-1] != op_b_i[XLEN-1]) ? op_a_i[XLEN-1] : diff[XLEN-1];

  assign is_branch_op = op_i inside {ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU};

  ////////////////////////////////////////
  // register result
  ////////////////////////////////////////

  always_comb begin
    case (op_i)
      ALU_ADD:  result_o = sum;
      ALU_SUB:  result_o = diff[XLEN-1:0];
      ALU_AND:  result_o = op_a_i & op_b_i;
      ALU_OR:   result_o = op_a_i | op_b_i;
      ALU_XOR:  result_o = op_a_i ^ op_b_i;
      ALU_SLT:  result_o = {{(XLEN-1){1'b0}}, less_s};
      ALU_SLTU: result_o = {{(XLEN-1){1'b0}}, less_u};
      // branch compares leave the result at zero
      default:  result_o = '0;
    endcase
  end

  ////////////////////////////////////////
  // branch compare flag
  ////////////////////////////////////////

  always_comb begin
    case (op_i)
      ALU_BEQ:  cmp_o = equal;
      ALU_BNE:  cmp_o = !equal;
      ALU_BLT:  cmp_o = less_s;
      ALU_BGE:  cmp_o = !less_s;
      ALU_BLTU: cmp_o = less_u;
      ALU_BGEU: cmp_o = !less_u;
      // non-branch operations never report a taken condition
      default:  cmp_o = 1'b0;
    endcase
  end

  ////////////////////////////////////////
  // assertions
  ////////////////////////////////////////

  // a held branch must never hand a nonzero value toward writeback
  // since the pipe control passes the ALU result through unchanged
  a_branch_zero_result :
    assert property (@(posedge clk) disable iff (reset_i)
                     (valid_i && is_branch_op) |-> (result_o == '0))
      else $error("ex_alu: branch op produced a nonzero result");

endmodule

// ==== rtl/ex_branch_unit.sv ====
// execute stage branch unit
// computes the branch target and the redirect decision, and inserts the
// fixed bubble count for branches under data-independent timing

`timescale 1ns/1ps

module ex_branch_unit
  import ex_pkg::*;
#(
  parameter int unsigned DIT_BUBBLES = 2
) (
  input  logic            clk,
  input  logic            reset_i,
  input  logic            valid_i,
  input  logic            branch_i,
  input  logic            dit_i,
  input  logic            compressed_i,
  input  logic [XLEN-1:0] pc_i,
  input  logic [XLEN-1:0] imm_i,
  input  logic            cmp_i,
  input  logic            advance_i,
  output logic            wait_o,
  output logic            redirect_o,
  output logic [XLEN-1:0] target_o
);

  // wide enough to hold the bubble count itself
  localparam int unsigned CNT_W = $clog2(DIT_BUBBLES + 1);

  logic             dit_branch;
  logic             started_q;
  logic [CNT_W-1:0] cnt_q;
  logic [CNT_W-1:0] owed;
  logic [XLEN-1:0]  fall_through;

  ////////////////////////////////////////
  // bubble counter
  ////////////////////////////////////////

  assign dit_branch = valid_i && branch_i && dit_i;

  // in the first held cycle the full count is owed, afterwards the counter holds it
  assign owed = started_q ? cnt_q : CNT_W'(DIT_BUBBLES);

  assign wait_o = dit_branch && (owed != '0);

  // the counter restarts whenever the held slot is empty, flushed or leaving
  always_ff @(posedge clk) begin
    if (reset_i) begin
      started_q <= 1'b0;
      cnt_q     <= '0;
    end else if (!valid_i || advance_i) begin
      started_q <= 1'b0;
      cnt_q     <= '0;
    end else if (dit_branch) begin
      started_q <= 1'b1;
      if (owed != '0) begin
        cnt_q <= owed - 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // target and redirect
  ////////////////////////////////////////

  assign fall_through = pc_i + (compressed_i ? PC_INC_C : PC_INC_U);

  // taken branches go to pc plus immediate, untaken dit branches to the next instruction
  assign target_o = cmp_i ? (pc_i + imm_i) : fall_through;

  // under dit every branch redirects so the fetch pattern does not depend on the data
  assign redirect_o = valid_i && branch_i && (cmp_i || dit_i);

  ////////////////////////////////////////
  // assertions
  ////////////////////////////////////////

  // a freshly held dit branch stays stalled for exactly the bubble count
  a_dit_bubbles :
    assert property (@(posedge clk) disable iff (reset_i || !valid_i)
                     (dit_branch && !started_q)
                     |-> (wait_o && !advance_i) [*DIT_BUBBLES] ##1 !wait_o)
      else $error("ex_branch_unit: dit branch bubble count mismatch");

  // an untaken dit branch still redirects, and it must land on the next instruction
  a_dit_untaken_target :
    assert property (@(posedge clk) disable iff (reset_i)
                     (redirect_o && dit_i && !cmp_i)
                     |-> (target_o == pc_i + (compressed_i ? PC_INC_C : PC_INC_U)))
      else $error("ex_branch_unit: untaken dit target is not the fall-through");

  // the pipe control must hold the instruction while bubbles are owed
  a_no_advance_in_wait :
    assert property (@(posedge clk) disable iff (reset_i)
                     advance_i |-> !wait_o)
      else $error("ex_branch_unit: advance while bubbles are still owed");

endmodule

// ==== rtl/ex_pipe_ctrl.sv ====
// execute stage pipeline control
// owns the decode-to-execute and execute-to-writeback registers, applies
// halt, kill and writeback back-pressure, and builds the writeback record

`timescale 1ns/1ps

module ex_pipe_ctrl
  import ex_pkg::*;
(
  input  logic            clk,
  input  logic            reset_i,
  // decode side
  input  logic            in_valid_i,
  input  alu_op_e         in_op_i,
  input  logic [XLEN-1:0] in_op_a_i,
  input  logic [XLEN-1:0] in_op_b_i,
  input  logic [XLEN-1:0] in_pc_i,
  input  logic [XLEN-1:0] in_imm_i,
  input  logic            in_branch_i,
  input  logic            in_compressed_i,
  input  logic            in_rf_we_i,
  input  logic            in_csr_en_i,
  input  logic            in_xif_en_i,
  input  logic            in_lsu_en_i,
  input  logic            in_lsu_split_i,
  output logic            ex_ready_o,
  // control levels
  input  logic            halt_i,
  input  logic            kill_i,
  input  logic            dit_en_i,
  input  logic            csr_illegal_i,
  // results from the ALU and branch unit
  input  logic [XLEN-1:0] alu_result_i,
  input  logic            br_wait_i,
  input  logic            br_redirect_i,
  input  logic [XLEN-1:0] br_target_i,
  // held instruction toward the ALU and branch unit
  output logic            valid_o,
  output alu_op_e         op_o,
  output logic [XLEN-1:0] op_a_o,
  output logic [XLEN-1:0] op_b_o,
  output logic [XLEN-1:0] pc_o,
  output logic [XLEN-1:0] imm_o,
  output logic            branch_o,
  output logic            compressed_o,
  output logic            dit_o,
  output logic            advance_o,
  // writeback slot
  input  logic            wb_ready_i,
  output logic            wb_valid_o,
  output logic [XLEN-1:0] wb_result_o,
  output logic            wb_rf_we_o,
  output logic            wb_csr_en_o,
  // pc redirect
  output logic            pc_set_o,
  output logic [XLEN-1:0] branch_target_o
);

  logic held_q;
  logic rf_we_q;
  logic csr_en_q;
  logic xif_en_q;
  logic lsu_en_q;
  logic lsu_split_q;
  logic accept;
  logic ex_valid;
  logic rf_we_merged;
  logic csr_en_merged;
  logic wb_valid_q;
  logic wb_rf_we_q;
  logic wb_csr_en_q;

  ////////////////////////////////////////
  // handshake
  ////////////////////////////////////////

  // the held instruction may leave only when nothing blocks it
  assign ex_valid  = held_q && !halt_i && !kill_i && !br_wait_i;
  assign advance_o = ex_valid && wb_ready_i;

  // kill always frees the slot, halt blocks refilling an empty one
  assign ex_ready_o = kill_i || (!held_q && !halt_i) || advance_o;
  assign accept     = in_valid_i && ex_ready_o;

  ////////////////////////////////////////
  // decode to execute register
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset_i) begin
      held_q <= 1'b0;
    end else if (accept) begin
      held_q <= 1'b1;
    end else if (kill_i || advance_o) begin
      held_q <= 1'b0;
    end
  end

  // the payload only changes on acceptance
  always_ff @(posedge clk) begin
    if (accept) begin
      op_o         <= in_op_i;
      op_a_o       <= in_op_a_i;
      op_b_o       <= in_op_b_i;
      pc_o         <= in_pc_i;
      imm_o        <= in_imm_i;
      branch_o     <= in_branch_i;
      compressed_o <= in_compressed_i;
      dit_o        <= dit_en_i;
      rf_we_q      <= in_rf_we_i;
      csr_en_q     <= in_csr_en_i;
      xif_en_q     <= in_xif_en_i;
      lsu_en_q     <= in_lsu_en_i;
      lsu_split_q  <= in_lsu_split_i;
    end
  end

  // a flushed instruction is hidden from the ALU and branch unit at once
  assign valid_o = held_q && !kill_i;

  ////////////////////////////////////////
  // result merge
  ////////////////////////////////////////

  // branches and the first half of a split load/store write no register
  assign rf_we_merged = rf_we_q && !branch_o && !(lsu_en_q && lsu_split_q);

  // the CSR write belongs to the extension interface or is dropped when illegal
  assign csr_en_merged = csr_en_q && !xif_en_q && !csr_illegal_i;

  // the redirect fires only in the cycle the branch leaves the stage
  assign pc_set_o        = advance_o && br_redirect_i;
  assign branch_target_o = br_target_i;

  ////////////////////////////////////////
  // execute to writeback register
  ////////////////////////////////////////

  // the slot is replaced or emptied only while writeback takes the old record
  always_ff @(posedge clk) begin
    if (reset_i) begin
      wb_valid_q <= 1'b0;
    end else if (wb_ready_i) begin
      wb_valid_q <= ex_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (advance_o) begin
      wb_result_o <= alu_result_i;
      wb_rf_we_q  <= rf_we_merged;
      wb_csr_en_q <= csr_en_merged;
    end
  end

  assign wb_valid_o  = wb_valid_q;
  // write enables are qualified so an empty slot never reports a write
  assign wb_rf_we_o  = wb_valid_q && wb_rf_we_q;
  assign wb_csr_en_o = wb_valid_q && wb_csr_en_q;

  ////////////////////////////////////////
  // assertions
  ////////////////////////////////////////

  // halt alone freezes the stage in both directions
  a_halt :
    assert property (@(posedge clk) disable iff (reset_i)
                     (halt_i && !kill_i) |-> (!ex_ready_o && !ex_valid))
      else $error("ex_pipe_ctrl: halt must give not ready and not valid");

  // kill flushes the held instruction and frees the slot
  a_kill :
    assert property (@(posedge clk) disable iff (reset_i)
                     kill_i |-> (ex_ready_o && !ex_valid))
      else $error("ex_pipe_ctrl: kill must give ready and not valid");

endmodule

// ==== rtl/ex_stage.sv ====
// execute stage top level
// connects the ALU, the branch unit and the pipeline control, and sets the
// bubble count used under data-independent timing

`timescale 1ns/1ps

module ex_stage
  import ex_pkg::*;
#(
  parameter int unsigned DIT_BUBBLES = 2
) (
  input  logic            clk,
  input  logic            reset_i,
  // decode handshake and instruction fields
  input  logic            in_valid_i,
  input  alu_op_e         in_op_i,
  input  logic [XLEN-1:0] in_op_a_i,
  input  logic [XLEN-1:0] in_op_b_i,
  input  logic [XLEN-1:0] in_pc_i,
  input  logic [XLEN-1:0] in_imm_i,
  input  logic            in_branch_i,
  input  logic            in_compressed_i,
  input  logic            in_rf_we_i,
  input  logic            in_csr_en_i,
  input  logic            in_xif_en_i,
  input  logic            in_lsu_en_i,
  input  logic            in_lsu_split_i,
  output logic            ex_ready_o,
  // control levels
  input  logic            halt_i,
  input  logic            kill_i,
  input  logic            dit_en_i,
  input  logic            csr_illegal_i,
  // writeback slot
  input  logic            wb_ready_i,
  output logic            wb_valid_o,
  output logic [XLEN-1:0] wb_result_o,
  output logic            wb_rf_we_o,
  output logic            wb_csr_en_o,
  // pc redirect
  output logic            pc_set_o,
  output logic [XLEN-1:0] branch_target_o
);

  // held instruction fanned out to the ALU and branch unit
  logic            held_valid;
  alu_op_e         held_op;
  logic [XLEN-1:0] held_op_a;
  logic [XLEN-1:0] held_op_b;
  logic [XLEN-1:0] held_pc;
  logic [XLEN-1:0] held_imm;
  logic            held_branch;
  logic            held_compressed;
  logic            held_dit;
  logic            ex_advance;

  // results returned to the pipeline control
  logic [XLEN-1:0] alu_result;
  logic            alu_cmp;
  logic            br_wait;
  logic            br_redirect;
  logic [XLEN-1:0] br_target;

  ex_alu i_ex_alu (
    .clk      (clk),
    .reset_i  (reset_i),
    .op_i     (held_op),
    .op_a_i   (held_op_a),
    .op_b_i   (held_op_b),
    .valid_i  (held_valid),
    .result_o (alu_result),
    .cmp_o    (alu_cmp)
  );

  ex_branch_unit #(
    .DIT_BUBBLES (DIT_BUBBLES)
  ) i_ex_branch_unit (
    .clk          (clk),
    .reset_i      (reset_i),
    .valid_i      (held_valid),
    .branch_i     (held_branch),
    .dit_i        (held_dit),
    .compressed_i (held_compressed),
    .pc_i         (held_pc),
    .imm_i        (held_imm),
    .cmp_i        (alu_cmp),
    .advance_i    (ex_advance),
    .wait_o       (br_wait),
    .redirect_o   (br_redirect),
    .target_o     (br_target)
  );

  ex_pipe_ctrl i_ex_pipe_ctrl (
    .clk             (clk),
    .reset_i         (reset_i),
    .in_valid_i      (in_valid_i),
    .in_op_i         (in_op_i),
    .in_op_a_i       (in_op_a_i),
    .in_op_b_i       (in_op_b_i),
    .in_pc_i         (in_pc_i),
    .in_imm_i        (in_imm_i),
    .in_branch_i     (in_branch_i),
    .in_compressed_i (in_compressed_i),
    .in_rf_we_i      (in_rf_we_i),
    .in_csr_en_i     (in_csr_en_i),
    .in_xif_en_i     (in_xif_en_i),
    .in_lsu_en_i     (in_lsu_en_i),
    .in_lsu_split_i  (in_lsu_split_i),
    .ex_ready_o      (ex_ready_o),
    .halt_i          (halt_i),
    .kill_i          (kill_i),
    .dit_en_i        (dit_en_i),
    .csr_illegal_i   (csr_illegal_i),
    .alu_result_i    (alu_result),
    .br_wait_i       (br_wait),
    .br_redirect_i   (br_redirect),
    .br_target_i     (br_target),
    .valid_o         (held_valid),
    .op_o            (held_op),
    .op_a_o          (held_op_a),
    .op_b_o          (held_op_b),
    .pc_o            (held_pc),
    .imm_o           (held_imm),
    .branch_o        (held_branch),
    .compressed_o    (held_compressed),
    .dit_o           (held_dit),
    .advance_o       (ex_advance),
    .wb_ready_i      (wb_ready_i),
    .wb_valid_o      (wb_valid_o),
    .wb_result_o     (wb_result_o),
    .wb_rf_we_o      (wb_rf_we_o),
    .wb_csr_en_o     (wb_csr_en_o),
    .pc_set_o        (pc_set_o),
    .branch_target_o (branch_target_o)
  );

endmodule

// ==== dv/ex_ref_model.svh ====
// execute stage reference model
// cycle model of the held slot and the writeback slot, built from the
// handshake, suppression and redirect rules of the stage

`ifndef EX_REF_MODEL_SVH
`define EX_REF_MODEL_SVH

// model state, mirrors the two registers of the stage
logic            m_held;
logic [3:0]      m_op;
logic [31:0]     m_a;
logic [31:0]     m_b;
logic [31:0]     m_pc;
logic [31:0]     m_imm;
logic            m_branch;
logic            m_compressed;
logic            m_dit;
logic            m_rf_we;
logic            m_csr_en;
logic            m_xif_en;
logic            m_lsu_en;
logic            m_lsu_split;
int              m_bubbles;
logic            m_wb_valid;
logic [31:0]     m_wb_result;
logic            m_wb_rf_we;
logic            m_wb_csr_en;

// expected combinational outputs for the current cycle
logic            exp_ready;
logic            exp_advance;
logic            exp_accept;
logic            exp_pc_set;
logic [31:0]     exp_target;

// register result of an operation, branch compares give zero
function automatic logic [31:0] expect_result(logic [3:0] op, logic [31:0] a, logic [31:0] b);
  case (op)
    4'h0: return a + b;
    4'h1: return a - b;
    4'h2: return a & b;
    4'h3: return a | b;
    4'h4: return a ^ b;
    4'h5: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    4'h6: return (a < b) ? 32'd1 : 32'd0;
    default: return 32'd0;
  endcase
endfunction

// branch condition as the ISA defines it
function automatic logic branch_taken(logic [3:0] op, logic [31:0] a, logic [31:0] b);
  case (op)
    4'h8: return a == b;
    4'h9: return a != b;
    4'hA: return $signed(a) < $signed(b);
    4'hB: return $signed(a) >= $signed(b);
    4'hC: return a < b;
    4'hD: return a >= b;
    default: return 1'b0;
  endcase
endfunction

// clears the model to the state right after reset
task automatic model_reset();
  m_held     = 1'b0;
  m_bubbles  = 0;
  m_wb_valid = 1'b0;
endtask

// works out what the stage should show in this cycle from the current inputs
task automatic model_eval();
  logic waiting;
  logic taken;
  waiting     = m_held && m_branch && m_dit && (m_bubbles != 0);
  exp_advance = m_held && !halt_i && !kill_i && !waiting && wb_ready_i;
  exp_ready   = kill_i || (!m_held && !halt_i) || exp_advance;
  exp_accept  = in_valid_i && exp_ready;
  taken       = branch_taken(m_op, m_a, m_b);
  exp_pc_set  = exp_advance && m_branch && (taken || m_dit);
  exp_target  = taken ? (m_pc + m_imm) : (m_pc + (m_compressed ? 32'd2 : 32'd4));
endtask

// advances the model across the coming clock edge
task automatic model_update();
  if (wb_ready_i) begin
    m_wb_valid = exp_advance;
  end
  if (exp_advance) begin
    m_wb_result = expect_result(m_op, m_a, m_b);
    m_wb_rf_we  = m_rf_we && !m_branch && !(m_lsu_en && m_lsu_split);
    m_wb_csr_en = m_csr_en && !m_xif_en && !csr_illegal_i;
  end
  // bubbles are paid off while held, halted or not
  if (m_held && !kill_i && m_bubbles != 0) begin
    m_bubbles = m_bubbles - 1;
  end
  if (exp_accept) begin
    m_held       = 1'b1;
    m_op         = in_op_i;
    m_a          = in_op_a_i;
    m_b          = in_op_b_i;
    m_pc         = in_pc_i;
    m_imm        = in_imm_i;
    m_branch     = in_branch_i;
    m_compressed = in_compressed_i;
    m_dit        = dit_en_i;
    m_rf_we      = in_rf_we_i;
    m_csr_en     = in_csr_en_i;
    m_xif_en     = in_xif_en_i;
    m_lsu_en     = in_lsu_en_i;
    m_lsu_split  = in_lsu_split_i;
    m_bubbles    = (in_branch_i && dit_en_i) ? DIT_BUBBLES : 0;
  end else if (kill_i || exp_advance) begin
    m_held = 1'b0;
  end
endtask

`endif

// ==== dv/ex_stage_tb.sv ====
// execute stage testbench
// random instruction streams against the cycle model, with back-pressure,
// halt, kill, CSR suppression and data-independent branch timing

`timescale 1ns/1ps

module ex_stage_tb
  import ex_pkg::*;
;

  localparam int DIT_BUBBLES = 2;
  localparam int N_PER_TEST  = 150;
  localparam int N_TESTS     = 5;
  localparam int RESET_CYC   = 16;
  // ten extra instructions per test cover the drain and the latency probe
  localparam int WATCHDOG_CYC = (N_TESTS * (N_PER_TEST + 10)) * (DIT_BUBBLES + 8) + RESET_CYC;

  logic            clk;
  logic            reset_i;
  logic            in_valid_i;
  alu_op_e         in_op_i;
  logic [XLEN-1:0] in_op_a_i;
  logic [XLEN-1:0] in_op_b_i;
  logic [XLEN-1:0] in_pc_i;
  logic [XLEN-1:0] in_imm_i;
  logic            in_branch_i;
  logic            in_compressed_i;
  logic            in_rf_we_i;
  logic            in_csr_en_i;
  logic            in_xif_en_i;
  logic            in_lsu_en_i;
  logic            in_lsu_split_i;
  logic            ex_ready_o;
  logic            halt_i;
  logic            kill_i;
  logic            dit_en_i;
  logic            csr_illegal_i;
  logic            wb_ready_i;
  logic            wb_valid_o;
  logic [XLEN-1:0] wb_result_o;
  logic            wb_rf_we_o;
  logic            wb_csr_en_o;
  logic            pc_set_o;
  logic [XLEN-1:0] branch_target_o;

  int total_errors;
  int test_errors;
  int tests_run;
  int accepted;
  int records;
  int redirects;

  `include "ex_ref_model.svh"

  ex_stage #(
    .DIT_BUBBLES (DIT_BUBBLES)
  ) i_ex_stage (
    .clk             (clk),
    .reset_i         (reset_i),
    .in_valid_i      (in_valid_i),
    .in_op_i         (in_op_i),
    .in_op_a_i       (in_op_a_i),
    .in_op_b_i       (in_op_b_i),
    .in_pc_i         (in_pc_i),
    .in_imm_i        (in_imm_i),
    .in_branch_i     (in_branch_i),
    .in_compressed_i (in_compressed_i),
    .in_rf_we_i      (in_rf_we_i),
    .in_csr_en_i     (in_csr_en_i),
    .in_xif_en_i     (in_xif_en_i),
    .in_lsu_en_i     (in_lsu_en_i),
    .in_lsu_split_i  (in_lsu_split_i),
    .ex_ready_o      (ex_ready_o),
    .halt_i          (halt_i),
    .kill_i          (kill_i),
    .dit_en_i        (dit_en_i),
    .csr_illegal_i   (csr_illegal_i),
    .wb_ready_i      (wb_ready_i),
    .wb_valid_o      (wb_valid_o),
    .wb_result_o     (wb_result_o),
    .wb_rf_we_o      (wb_rf_we_o),
    .wb_csr_en_o     (wb_csr_en_o),
    .pc_set_o        (pc_set_o),
    .branch_target_o (branch_target_o)
  );

  ////////////////////////////////////////
  // clock and watchdog
  ////////////////////////////////////////

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    repeat (WATCHDOG_CYC) @(posedge clk);
    $display("timeout: the tests did not finish within %0d cycles", WATCHDOG_CYC);
    $display("Checks failed");
    $finish;
  end

  ////////////////////////////////////////
  // checking
  ////////////////////////////////////////

  task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s got %h expected %h at %0t", name, got, exp, $time);
      total_errors++;
      test_errors++;
    end
  endtask

  // compares the outputs sampled mid-cycle, then moves the model across the edge
  task automatic step_and_check();
    model_eval();
    check_value("ex_ready_o", 32'(ex_ready_o), 32'(exp_ready));
    check_value("pc_set_o", 32'(pc_set_o), 32'(exp_pc_set));
    if (exp_pc_set) begin
      check_value("branch_target_o", branch_target_o, exp_target);
      redirects++;
    end
    check_value("wb_valid_o", 32'(wb_valid_o), 32'(m_wb_valid));
    check_value("wb_rf_we_o", 32'(wb_rf_we_o), 32'(m_wb_valid && m_wb_rf_we));
    check_value("wb_csr_en_o", 32'(wb_csr_en_o), 32'(m_wb_valid && m_wb_csr_en));
    if (m_wb_valid) begin
      check_value("wb_result_o", wb_result_o, m_wb_result);
    end
    if (m_wb_valid && wb_ready_i) begin
      records++;
    end
    if (exp_accept) begin
      accepted++;
    end
    model_update();
  endtask

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  task automatic drive_idle();
    in_valid_i      = 1'b0;
    in_op_i         = ALU_ADD;
    in_op_a_i       = '0;
    in_op_b_i       = '0;
    in_pc_i         = '0;
    in_imm_i        = '0;
    in_branch_i     = 1'b0;
    in_compressed_i = 1'b0;
    in_rf_we_i      = 1'b0;
    in_csr_en_i     = 1'b0;
    in_xif_en_i     = 1'b0;
    in_lsu_en_i     = 1'b0;
    in_lsu_split_i  = 1'b0;
    halt_i          = 1'b0;
    kill_i          = 1'b0;
    dit_en_i        = 1'b0;
    csr_illegal_i   = 1'b0;
    wb_ready_i      = 1'b1;
  endtask

  // mode selects which controls are randomized, see the test list below
  task automatic drive_random(int mode);
    logic is_br;
    is_br = (mode == 3 || mode == 5) && ($urandom_range(0, 2) == 0);
    in_valid_i  = ($urandom_range(0, 9) < 7);
    in_branch_i = is_br;
    if (is_br) begin
      in_op_i = alu_op_e'(ALU_OP_W'(8 + $urandom_range(0, 5)));
    end else begin
      in_op_i = alu_op_e'(ALU_OP_W'($urandom_range(0, 6)));
    end
    in_op_a_i = $urandom;
    // equal operands now and then so the equality compares both ways
    in_op_b_i       = ($urandom_range(0, 3) == 0) ? in_op_a_i : $urandom;
    in_pc_i         = $urandom & 32'hffff_fffe;
    in_imm_i        = $urandom & 32'h0000_fffe;
    in_compressed_i = ($urandom_range(0, 1) == 1);
    in_rf_we_i      = ($urandom_range(0, 3) != 0);
    in_csr_en_i     = (mode == 4) && ($urandom_range(0, 1) == 1);
    in_xif_en_i     = (mode == 4) && ($urandom_range(0, 2) == 0);
    in_lsu_en_i     = (mode == 4) && ($urandom_range(0, 1) == 1);
    in_lsu_split_i  = (mode == 4) && ($urandom_range(0, 1) == 1);
    csr_illegal_i   = (mode == 4) && ($urandom_range(0, 3) == 0);
    dit_en_i        = (mode == 5) && ($urandom_range(0, 1) == 1);
    halt_i          = (mode == 2 || mode == 3) && ($urandom_range(0, 6) == 0);
    kill_i          = (mode == 3) && ($urandom_range(0, 9) == 0);
    wb_ready_i      = (mode == 2 || mode == 3) ? ($urandom_range(0, 9) < 7) : 1'b1;
  endtask

  // lets the stage empty out so the next test starts clean
  task automatic drain();
    int n;
    n = 0;
    while ((m_held || m_wb_valid) && n < 50) begin
      @(posedge clk);
      #1;
      drive_idle();
      @(negedge clk);
      step_and_check();
      n++;
    end
    if (m_held || m_wb_valid) begin
      $display("the stage did not empty after the test stream ended");
      total_errors++;
      test_errors++;
    end
  endtask

  task automatic run_test(int mode, string title);
    test_errors = 0;
    records     = 0;
    redirects   = 0;
    accepted    = 0;
    while (accepted < N_PER_TEST) begin
      @(posedge clk);
      #1;
      drive_random(mode);
      @(negedge clk);
      step_and_check();
    end
    drain();
    tests_run++;
    $display("test %0d %s: %0d accepted, %0d records, %0d redirects, %0d errors",
             mode, title, accepted, records, redirects, test_errors);
  endtask

  // a lone dit branch, counted from its acceptance cycle to its record
  task automatic dit_latency();
    int k;
    test_errors = 0;
    @(posedge clk);
    #1;
    drive_idle();
    in_valid_i  = 1'b1;
    in_branch_i = 1'b1;
    in_op_i     = ALU_BNE;
    in_op_a_i   = 32'h0000_1234;
    in_op_b_i   = 32'h0000_1234;
    in_pc_i     = 32'h0000_8000;
    dit_en_i    = 1'b1;
    @(negedge clk);
    step_and_check();
    k = 0;
    while (!wb_valid_o && k < 4 * DIT_BUBBLES + 8) begin
      @(posedge clk);
      #1;
      drive_idle();
      @(negedge clk);
      step_and_check();
      k++;
    end
    check_value("dit_latency", 32'(k), 32'(DIT_BUBBLES + 2));
    drain();
    tests_run++;
    $display("test 6 dit latency: record %0d cycles after acceptance, %0d errors",
             k, test_errors);
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial begin
    void'($urandom(32'h3e01b408));
    total_errors = 0;
    tests_run    = 0;
    drive_idle();
    reset_i = 1'b1;
    repeat (RESET_CYC) @(posedge clk);
    #1;
    reset_i = 1'b0;
    model_reset();

    run_test(1, "alu stream");
    run_test(2, "back-pressure and halt");
    run_test(3, "kill");
    run_test(4, "csr and split suppression");
    run_test(5, "branches with dit");
    dit_latency();

    $display("%0d tests run, %0d errors", tests_run, total_errors);
    if (total_errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+dv
rtl/ex_pkg.sv
rtl/ex_alu.sv
rtl/ex_branch_unit.sv
rtl/ex_pipe_ctrl.sv
rtl/ex_stage.sv
dv/ex_stage_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the execute stage testbench with Verilator and runs it
# the run counts as failed if any step fails or the log shows the fail message

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=ex_stage_sim

verilator --binary --timing --assert \
  -f sources.f \
  --top-module ex_stage_tb \
  -o "$BIN"
status=$?
if [ $status -ne 0 ]; then
  echo "build failed with status $status"
  exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Checks failed" "$LOG"; then
  echo "simulation reported failures"
  exit 1
fi

if ! grep -q "All checks passed" "$LOG"; then
  echo "simulation ended without a result"
  exit 1
fi

echo "simulation passed"
exit 0
